/* riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_PC4,
        WB_MEM,
        WB_IMM
    } wb_sel_e;

    // Operand source in EX
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_e;

    typedef struct packed {
        logic    rs1_re;
        logic    rs2_re;
        logic    rf_we;
        wb_sel_e wb_sel;
        logic    src1_pc;   // ALU operand 1 is the PC
        logic    src2_imm;  // ALU operand 2 is the immediate
        alu_op_e alu_op;
        logic    branch;
        logic    branch_ne;
        logic    jal;
        logic    mem_we;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc4;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   pc4;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   rd1;
        logic [XLEN-1:0]   rd2;
        logic [XLEN-1:0]   imm;
        ctrl_t             ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [REG_AW-1:0] rd;
        ctrl_t             ctrl;
        logic [XLEN-1:0]   alu_ans;
        logic [XLEN-1:0]   pc4;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   store_data;
    } ex_mem_t;

    typedef struct packed {
        logic [REG_AW-1:0] rd;
        logic              rf_we;
        wb_sel_e           wb_sel;
        logic [XLEN-1:0]   alu_ans;
        logic [XLEN-1:0]   pc4;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   load_data;
    } mem_wb_t;

endpackage

`default_nettype wire

/* hazard_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface hazard_if import riscv_pkg::*; (
    input logic clk,
    input logic rst_n
);
    logic [REG_AW-1:0] rs1_ex;
    logic [REG_AW-1:0] rs2_ex;
    logic              rs1_re_ex;
    logic              rs2_re_ex;
    logic [REG_AW-1:0] rd_mem;
    logic              rf_we_mem;
    logic              load_mem;
    logic [REG_AW-1:0] rd_wb;
    logic              rf_we_wb;
    logic              redirect;   // Taken branch or JAL in EX
    fwd_e              fwd1;
    fwd_e              fwd2;
    logic              stall_if;
    logic              stall_id;
    logic              flush_id;
    logic              flush_ex;

    modport ctrl (
        input  clk, rst_n,
        input  rs1_ex, rs2_ex, rs1_re_ex, rs2_re_ex,
        input  rd_mem, rf_we_mem, load_mem, rd_wb, rf_we_wb, redirect,
        output fwd1, fwd2, stall_if, stall_id, flush_id, flush_ex
    );

    modport exec (
        output rs1_ex, rs2_ex, rs1_re_ex, rs2_re_ex, redirect,
        input  fwd1, fwd2, stall_id
    );

    modport fetch (
        input stall_if, flush_id, redirect
    );

    modport core (
        output rd_mem, rf_we_mem, load_mem, rd_wb, rf_we_wb,
        input  stall_id, flush_id, flush_ex
    );

endinterface

`default_nettype wire

/* hazard_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazard_unit import riscv_pkg::*; (
    hazard_if.ctrl hz
);
    logic mem_ok;
    logic wb_ok;
    logic load_use;

    assign mem_ok = hz.rf_we_mem && hz.rd_mem != '0 && !hz.load_mem;
    assign wb_ok  = hz.rf_we_wb && hz.rd_wb != '0;

    // Memory stage is younger, so it wins over write-back
    function automatic fwd_e fwd_pick(input logic [REG_AW-1:0] rs);
        if (mem_ok && hz.rd_mem == rs)
            return FWD_MEM;
        else if (wb_ok && hz.rd_wb == rs)
            return FWD_WB;
        else
            return FWD_NONE;
    endfunction

    always_comb begin
        hz.fwd1 = fwd_pick(hz.rs1_ex);
        hz.fwd2 = fwd_pick(hz.rs2_ex);
    end

    // Load in MEM feeding EX, data only exists in WB next cycle
    assign load_use = hz.load_mem && hz.rd_mem != '0 &&
                      ((hz.rs1_re_ex && hz.rs1_ex == hz.rd_mem) ||
                       (hz.rs2_re_ex && hz.rs2_ex == hz.rd_mem));

    // EX holds and emits a bubble, so IF and ID must hold as well
    assign hz.stall_if = load_use;
    assign hz.stall_id = load_use;

    assign hz.flush_id = hz.redirect;   // Drops the two younger instructions
    assign hz.flush_ex = hz.redirect;

    // A load-use hold never meets a redirect and lasts one cycle only
    assert property (@(posedge hz.clk) disable iff (!hz.rst_n)
        hz.stall_if |-> !hz.flush_id ##1 !hz.stall_if);

endmodule

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_stage import riscv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    hazard_if.fetch         hz,
    input  logic [XLEN-1:0] target,
    output logic [XLEN-1:0] im_addr,
    input  logic [XLEN-1:0] im_dout,
    output if_id_t          if_out
);
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc4;

    assign pc4 = pc + XLEN'(4);

    always_ff @(posedge clk) begin
        if (!rst_n)
            pc <= RESET_PC;
        else if (hz.redirect)
            pc <= target;
        else if (!hz.stall_if)
            pc <= pc4;
    end

    assign im_addr = pc;

    // Wrong-path word becomes a no-op
    assign if_out = '{
        pc:    pc,
        pc4:   pc4,
        instr: hz.flush_id ? NOP_INSTR : im_dout
    };

endmodule

`default_nettype wire

/* decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module decoder import riscv_pkg::*; (
    input  logic [XLEN-1:0] instr,
    output ctrl_t           ctrl,
    output logic [XLEN-1:0] imm
);
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    alu_op_e         r_op;
    logic            r_ok;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // R-type function fields
    always_comb begin
        r_ok = 1'b1;
        r_op = ALU_ADD;
        case ({funct7, funct3})
            10'b0000000_000: r_op = ALU_ADD;
            10'b0100000_000: r_op = ALU_SUB;
            10'b0000000_010: r_op = ALU_SLT;
            10'b0000000_100: r_op = ALU_XOR;
            10'b0000000_110: r_op = ALU_OR;
            10'b0000000_111: r_op = ALU_AND;
            default:         r_ok = 1'b0;
        endcase
    end

    always_comb begin
        ctrl = '0;   // Anything unlisted runs as a no-op
        imm  = '0;
        case (instr[6:0])
            OPC_OP: if (r_ok) begin
                ctrl.rs1_re = 1'b1;
                ctrl.rs2_re = 1'b1;
                ctrl.rf_we  = 1'b1;
                ctrl.alu_op = r_op;
            end
            OPC_OP_IMM: if (funct3 == 3'b000) begin   // ADDI only
                ctrl.rs1_re   = 1'b1;
                ctrl.rf_we    = 1'b1;
                ctrl.src2_imm = 1'b1;
                imm           = imm_i;
            end
            OPC_LUI: begin
                ctrl.rf_we  = 1'b1;
                ctrl.wb_sel = WB_IMM;
                imm         = imm_u;
            end
            OPC_LOAD: if (funct3 == 3'b010) begin
                ctrl.rs1_re   = 1'b1;
                ctrl.rf_we    = 1'b1;
                ctrl.wb_sel   = WB_MEM;
                ctrl.src2_imm = 1'b1;
                imm           = imm_i;
            end
            OPC_STORE: if (funct3 == 3'b010) begin
                ctrl.rs1_re   = 1'b1;
                ctrl.rs2_re   = 1'b1;
                ctrl.src2_imm = 1'b1;
                ctrl.mem_we   = 1'b1;
                imm           = imm_s;
            end
            OPC_BRANCH: if (funct3[2:1] == 2'b00) begin   // BEQ, BNE
                ctrl.rs1_re    = 1'b1;
                ctrl.rs2_re    = 1'b1;
                ctrl.src1_pc   = 1'b1;   // ALU forms the target
                ctrl.src2_imm  = 1'b1;
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = funct3[0];
                imm            = imm_b;
            end
            OPC_JAL: begin
                ctrl.rf_we    = 1'b1;
                ctrl.wb_sel   = WB_PC4;
                ctrl.src1_pc  = 1'b1;
                ctrl.src2_imm = 1'b1;
                ctrl.jal      = 1'b1;
                imm           = imm_j;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file import riscv_pkg::*; (
    input  logic              clk,
    input  logic [REG_AW-1:0] ra1,
    input  logic [REG_AW-1:0] ra2,
    input  logic [REG_AW-1:0] wa,
    input  logic              we,
    input  logic [XLEN-1:0]   wd,
    output logic [XLEN-1:0]   rd1,
    output logic [XLEN-1:0]   rd2
);
    logic [XLEN-1:0] regs [2**REG_AW];

    always_ff @(posedge clk) begin
        if (we && wa != '0)
            regs[wa] <= wd;
    end

    // Same-cycle write is visible to the reader, except a write aimed at x0
    assign rd1 = (we && wa != '0 && wa == ra1) ? wd : (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (we && wa != '0 && wa == ra2) ? wd : (ra2 == '0) ? '0 : regs[ra2];

    // x0 stays zero even through the bypass
    assert property (@(posedge clk)
        (ra1 != '0 || rd1 == '0) && (ra2 != '0 || rd2 == '0));

endmodule

`default_nettype wire

/* exec_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_stage import riscv_pkg::*; (
    input  id_ex_t          ex_in,
    hazard_if.exec          hz,
    input  logic [XLEN-1:0] fwd_mem,
    input  logic [XLEN-1:0] fwd_wb,
    output ex_mem_t         ex_out,
    output logic [XLEN-1:0] target
);
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] alu_ans;
    logic            taken;

    function automatic logic [XLEN-1:0] fwd_mux(input fwd_e            sel,
                                                 input logic [XLEN-1:0] rf_val);
        case (sel)
            FWD_MEM: return fwd_mem;
            FWD_WB:  return fwd_wb;
            default: return rf_val;
        endcase
    endfunction

    assign hz.rs1_ex    = ex_in.rs1;
    assign hz.rs2_ex    = ex_in.rs2;
    assign hz.rs1_re_ex = ex_in.ctrl.rs1_re;
    assign hz.rs2_re_ex = ex_in.ctrl.rs2_re;

    always_comb begin
        op1 = fwd_mux(hz.fwd1, ex_in.rd1);
        op2 = fwd_mux(hz.fwd2, ex_in.rd2);
    end

    assign src1 = ex_in.ctrl.src1_pc ? ex_in.pc : op1;
    assign src2 = ex_in.ctrl.src2_imm ? ex_in.imm : op2;

    always_comb begin
        case (ex_in.ctrl.alu_op)
            ALU_SUB: alu_ans = src1 - src2;
            ALU_AND: alu_ans = src1 & src2;
            ALU_OR:  alu_ans = src1 | src2;
            ALU_XOR: alu_ans = src1 ^ src2;
            ALU_SLT: alu_ans = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            default: alu_ans = src1 + src2;
        endcase
    end

    assign taken = ex_in.ctrl.jal ||
                   (ex_in.ctrl.branch && ((op1 == op2) ^ ex_in.ctrl.branch_ne));

    // Operands are stale while held on a load-use
    assign hz.redirect = taken && !hz.stall_id;
    assign target      = alu_ans;   // PC + imm

    assign ex_out = '{
        rd:         ex_in.rd,
        ctrl:       hz.stall_id ? ctrl_t'('0) : ex_in.ctrl,   // Bubble into MEM
        alu_ans:    alu_ans,
        pc4:        ex_in.pc4,
        imm:        ex_in.imm,
        store_data: op2
    };

endmodule

`default_nettype wire

/* pipe_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
    parameter type T         = logic [31:0],
    parameter T    FLUSH_VAL = T'(0)
) (
    input  logic clk,
    input  logic rst_n,
    input  logic stall,
    input  logic flush,
    input  T     d,
    output T     q
);
    always_ff @(posedge clk) begin
        if (!rst_n || flush)
            q <= FLUSH_VAL;
        else if (!stall)
            q <= d;
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(stall && flush));

endmodule

`default_nettype wire

/* riscv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_core import riscv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    output logic [XLEN-1:0] im_addr,
    input  logic [XLEN-1:0] im_dout,
    output logic [XLEN-1:0] mem_addr,
    output logic [XLEN-1:0] mem_din,
    output logic            mem_we,
    input  logic [XLEN-1:0] mem_dout
);
    localparam if_id_t IF_ID_NOP = '{pc: '0, pc4: '0, instr: NOP_INSTR};

    if_id_t          if_d;
    if_id_t          if_q;
    id_ex_t          id_d;
    id_ex_t          id_q;
    ex_mem_t         ex_d;
    ex_mem_t         ex_q;
    mem_wb_t         wb_d;
    mem_wb_t         wb_q;
    ctrl_t           id_ctrl;
    logic [XLEN-1:0] id_imm;
    logic [XLEN-1:0] rf_rd1;
    logic [XLEN-1:0] rf_rd2;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] fwd_mem;
    logic [XLEN-1:0] wb_data;

    function automatic logic [XLEN-1:0] wb_select(input wb_sel_e         sel,
                                                   input logic [XLEN-1:0] alu_ans,
                                                   input logic [XLEN-1:0] pc4,
                                                   input logic [XLEN-1:0] load_data,
                                                   input logic [XLEN-1:0] imm);
        case (sel)
            WB_PC4:  return pc4;
            WB_MEM:  return load_data;
            WB_IMM:  return imm;
            default: return alu_ans;
        endcase
    endfunction

    hazard_if hz (.clk(clk), .rst_n(rst_n));

    hazard_unit hazard_i (.hz(hz));

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .hz      (hz),
        .target  (target),
        .im_addr (im_addr),
        .im_dout (im_dout),
        .if_out  (if_d)
    );

    pipe_reg #(.T(if_id_t), .FLUSH_VAL(IF_ID_NOP)) if_id_i (
        .clk(clk), .rst_n(rst_n), .stall(hz.stall_id), .flush(hz.flush_id), .d(if_d), .q(if_q)
    );

    decoder dec_i (.instr(if_q.instr), .ctrl(id_ctrl), .imm(id_imm));

    reg_file rf_i (
        .clk (clk),
        .ra1 (if_q.instr[19:15]),
        .ra2 (if_q.instr[24:20]),
        .wa  (wb_q.rd),
        .we  (wb_q.rf_we),
        .wd  (wb_data),
        .rd1 (rf_rd1),
        .rd2 (rf_rd2)
    );

    assign id_d = '{
        pc:   if_q.pc,
        pc4:  if_q.pc4,
        rs1:  if_q.instr[19:15],
        rs2:  if_q.instr[24:20],
        rd:   if_q.instr[11:7],
        rd1:  rf_rd1,
        rd2:  rf_rd2,
        imm:  id_imm,
        ctrl: id_ctrl
    };

    // Held together with IF/ID while EX waits on a load
    pipe_reg #(.T(id_ex_t), .FLUSH_VAL('0)) id_ex_i (
        .clk(clk), .rst_n(rst_n), .stall(hz.stall_id), .flush(hz.flush_ex), .d(id_d), .q(id_q)
    );

    exec_stage exec_i (
        .ex_in   (id_q),
        .hz      (hz),
        .fwd_mem (fwd_mem),
        .fwd_wb  (wb_data),
        .ex_out  (ex_d),
        .target  (target)
    );

    pipe_reg #(.T(ex_mem_t), .FLUSH_VAL('0)) ex_mem_i (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0), .d(ex_d), .q(ex_q)
    );

    assign mem_addr = ex_q.alu_ans;
    assign mem_din  = ex_q.store_data;
    assign mem_we   = ex_q.ctrl.mem_we;

    // Loads never take this path, the hazard unit waits for write-back
    assign fwd_mem = wb_select(ex_q.ctrl.wb_sel, ex_q.alu_ans, ex_q.pc4, mem_dout, ex_q.imm);

    assign hz.rd_mem    = ex_q.rd;
    assign hz.rf_we_mem = ex_q.ctrl.rf_we;
    assign hz.load_mem  = ex_q.ctrl.rf_we && ex_q.ctrl.wb_sel == WB_MEM;

    assign wb_d = '{
        rd:        ex_q.rd,
        rf_we:     ex_q.ctrl.rf_we,
        wb_sel:    ex_q.ctrl.wb_sel,
        alu_ans:   ex_q.alu_ans,
        pc4:       ex_q.pc4,
        imm:       ex_q.imm,
        load_data: mem_dout
    };

    pipe_reg #(.T(mem_wb_t), .FLUSH_VAL('0)) mem_wb_i (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0), .d(wb_d), .q(wb_q)
    );

    assign wb_data = wb_select(wb_q.wb_sel, wb_q.alu_ans, wb_q.pc4, wb_q.load_data, wb_q.imm);

    assign hz.rd_wb    = wb_q.rd;
    assign hz.rf_we_wb = wb_q.rf_we;

endmodule

`default_nettype wire

/* tb_riscv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_riscv_core;

    localparam logic [31:0] RESET_PC       = 32'h0000_0000;
    localparam int          TIMEOUT_CYCLES = 500;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] im_addr;
    logic [31:0] im_dout;
    logic [31:0] mem_addr;
    logic [31:0] mem_din;
    logic        mem_we;
    logic [31:0] mem_dout;

    logic [31:0] rom [64];
    logic [31:0] ram [256];
    store_t      store_q [$];
    int          expected_left;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    logic [31:0] prev_addr;
    logic        prev_redirect;
    logic [31:0] lcg_state;
    int          emit_idx;

    riscv_core #(.RESET_PC(RESET_PC)) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .im_addr  (im_addr),
        .im_dout  (im_dout),
        .mem_addr (mem_addr),
        .mem_din  (mem_din),
        .mem_we   (mem_we),
        .mem_dout (mem_dout)
    );

    always #50 clk = ~clk;

    // Both memories answer in the same cycle
    assign im_dout  = rom[im_addr[7:2]];
    assign mem_dout = ram[mem_addr[9:2]];

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return {idx[15:0] ^ 16'hC3A5, ~idx[15:0]};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input logic [31:0] imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] lw(input int rd, input int rs1, input logic [31:0] imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input int rs2, input int rs1, input logic [31:0] imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1, input int rs2,
                                           input logic [31:0] off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] lui(input int rd, input logic [19:0] imm);
        return {imm, rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] jal(input int rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] instr);
        rom[emit_idx] = instr;
        emit_idx++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        store_q.push_back('{addr: addr, data: data});
    endtask

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // Program and expected stores, built side by side from the ISA rules
    task automatic build_program();
        logic [31:0] rnd;
        logic [11:0] a;
        logic [11:0] b;
        logic [11:0] c;
        logic [19:0] u;
        logic [31:0] x [16];
        int          i;
        for (i = 0; i < 64; i++)
            rom[i] = 32'h0000_0013;
        for (i = 0; i < 256; i++)
            ram[i] = fill_word(i);
        emit_idx = 0;
        rnd = lcg_next();
        a = rnd[27:16];
        rnd = lcg_next();
        b = rnd[27:16];
        if (b == 12'd0)
            b = 12'd1;   // Keeps BNE x1,x2 taken
        rnd = lcg_next();
        c = rnd[27:16];
        rnd = lcg_next();
        u = rnd[31:12];

        emit(addi(1, 0, sext12(a)));
        x[1] = sext12(a);
        emit(addi(2, 1, sext12(b)));
        x[2] = x[1] + sext12(b);
        emit(r_type(7'h00, 3'b000, 3, 2, 1));   // x2 from MEM, x1 from WB
        x[3] = x[2] + x[1];
        emit(r_type(7'h20, 3'b000, 4, 3, 2));
        x[4] = x[3] - x[2];
        emit(r_type(7'h00, 3'b100, 5, 4, 3));
        x[5] = x[4] ^ x[3];
        emit(r_type(7'h00, 3'b111, 6, 5, 4));
        x[6] = x[5] & x[4];
        emit(r_type(7'h00, 3'b110, 7, 6, 5));
        x[7] = x[6] | x[5];
        emit(r_type(7'h00, 3'b010, 8, 7, 6));
        x[8] = ($signed(x[7]) < $signed(x[6])) ? 32'd1 : 32'd0;
        emit(r_type(7'h00, 3'b000, 9, 8, 7));
        x[9] = x[8] + x[7];
        emit(sw(9, 0, 32'h100));
        expect_store(32'h100, x[9]);
        emit(sw(7, 0, 32'h104));
        expect_store(32'h104, x[7]);

        // Load followed at once by its consumer
        emit(addi(10, 0, sext12(c)));
        x[10] = sext12(c);
        emit(sw(10, 0, 32'h108));
        expect_store(32'h108, x[10]);
        emit(lw(11, 0, 32'h180));
        x[11] = fill_word(32'h180 >> 2);
        emit(r_type(7'h00, 3'b000, 12, 11, 10));
        x[12] = x[11] + x[10];
        emit(sw(12, 0, 32'h10C));
        expect_store(32'h10C, x[12]);

        emit(branch(3'b000, 1, 1, 32'd8));   // BEQ taken
        emit(sw(1, 0, 32'h110));
        emit(branch(3'b001, 1, 2, 32'd8));   // BNE taken
        emit(sw(2, 0, 32'h114));
        emit(branch(3'b001, 1, 1, 32'd8));   // BNE falls through
        emit(sw(3, 0, 32'h118));
        expect_store(32'h118, x[3]);

        x[13] = RESET_PC + 32'(emit_idx * 4) + 32'd4;
        emit(jal(13, 32'd8));
        emit(sw(1, 0, 32'h11C));
        emit(sw(13, 0, 32'h120));
        expect_store(32'h120, x[13]);
        emit(lui(14, u));
        x[14] = {u, 12'h000};
        emit(sw(14, 0, 32'h124));
        expect_store(32'h124, x[14]);
        emit(jal(0, 32'd0));   // Spin here
    endtask

    // Scoreboard head advances on every store
    always @(posedge clk) begin
        prev_addr     <= im_addr;
        prev_redirect <= dut_i.hz.redirect;
        if (mem_we)
            ram[mem_addr[9:2]] <= mem_din;
        if (rst_n && mem_we && store_q.size() > 0) begin
            void'(store_q.pop_front());
            expected_left <= store_q.size();
            if (store_q.size() > 0) begin
                exp_addr <= store_q[0].addr;
                exp_data <= store_q[0].data;
            end
        end
    end

    assert property (@(posedge clk) !rst_n |=> !mem_we)
        else stop_on_error($sformatf("Error: %0t mem_we expected 0 got %b",
                                     $time, $sampled(mem_we)));

    assert property (@(posedge clk) !rst_n |=> im_addr == RESET_PC)
        else stop_on_error($sformatf("Error: %0t im_addr expected %h got %h",
                                     $time, RESET_PC, $sampled(im_addr)));

    assert property (@(posedge clk) disable iff (!rst_n)
        !prev_redirect |-> (im_addr == prev_addr + 32'd4 || im_addr == prev_addr))
        else stop_on_error($sformatf("Error: %0t im_addr expected %h or %h got %h", $time,
                                     $sampled(prev_addr) + 32'd4, $sampled(prev_addr),
                                     $sampled(im_addr)));

    assert property (@(posedge clk) disable iff (!rst_n) mem_we |-> expected_left != 0)
        else stop_on_error($sformatf("Unexpected store to address %h at %0t after the last one",
                                     $sampled(mem_addr), $time));

    assert property (@(posedge clk) disable iff (!rst_n) mem_we |-> mem_addr == exp_addr)
        else stop_on_error($sformatf("Error: %0t mem_addr expected %h got %h",
                                     $time, $sampled(exp_addr), $sampled(mem_addr)));

    assert property (@(posedge clk) disable iff (!rst_n) mem_we |-> mem_din == exp_data)
        else stop_on_error($sformatf("Error: %0t mem_din expected %h got %h",
                                     $time, $sampled(exp_data), $sampled(mem_din)));

    initial begin
        int cycles;
        rst_n     = 1'b0;
        lcg_state = 32'd90251;
        build_program();
        exp_addr      = store_q[0].addr;
        exp_data      = store_q[0].data;
        expected_left = store_q.size();
        repeat (5) @(posedge clk);
        #10 rst_n = 1'b1;
        cycles = 0;
        while (expected_left != 0 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (expected_left == 0) begin
            repeat (10) @(negedge clk);   // Room for a stray late store
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Program did not finish, %0d stores missing after %0d cycles",
                     expected_left, cycles);
            $display("Testbench failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* tb.f */
riscv_pkg.sv
hazard_if.sv
hazard_unit.sv
fetch_stage.sv
decoder.sv
reg_file.sv
exec_stage.sv
pipe_reg.sv
riscv_core.sv
tb_riscv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_riscv_core
FLAGS     ?=
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --assert --timescale 1ns/100ps \
		-f tb.f --top-module $(TOP) --Mdir $(OBJ_DIR) $(FLAGS)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
